//--- logic/rsa256_pkg.sv
package rsa256_pkg;

    // Avalon-MM master bus types
    typedef logic [4:0]  avm_addr_t;
    typedef logic [31:0] avm_word_t;

    // Serial peripheral register map, byte offsets
    localparam avm_addr_t rx_base     = 5'd0;
    localparam avm_addr_t tx_base     = 5'd4;
    localparam avm_addr_t status_base = 5'd8;

    // STATUS word flags
    localparam int tx_ok_bit = 6;
    localparam int rx_ok_bit = 7;

    // Host controller FSM
    typedef enum logic [2:0] {
        get_key,    // Poll STATUS for an RX byte
        get_data,   // Read one byte from RX
        wait_calc,  // Core is busy
        get_tx,     // Poll STATUS for TX room
        send_data   // Write one byte to TX
    } ctrl_state_t;

    // Exponentiation core sequencer
    typedef enum logic [1:0] {
        idle,
        prep,   // a * 2^KEY_W mod n
        loop,   // One square-and-multiply round per exponent bit
        done
    } core_state_t;

endpackage

//--- logic/rsa_mod_prod.sv
`timescale 1ns/10ps

// Computes a * 2^KEY_W mod n, one modular doubling per cycle
module rsa_mod_prod #(
    parameter int KEY_W = 256
) (
    input  logic             avm_clk,
    input  logic             avm_rst,
    input  logic             start,
    input  logic [KEY_W-1:0] a,
    input  logic [KEY_W-1:0] n,
    output logic [KEY_W-1:0] prod,
    output logic             done
);

    localparam int CNT_W = $clog2(KEY_W);

    logic             busy;
    logic [CNT_W-1:0] cnt;
    logic [KEY_W-1:0] acc;
    logic [KEY_W:0]   dbl;      // 2 * acc, below 2n
    logic [KEY_W:0]   reduced;
    logic             last;

    assign dbl     = {acc, 1'b0};
    assign reduced = (dbl >= {1'b0, n}) ? dbl - {1'b0, n} : dbl;
    assign last    = (cnt == CNT_W'(KEY_W - 1));
    assign prod    = acc;

    always_ff @(posedge avm_clk or negedge avm_rst) begin
        if (!avm_rst) begin
            busy <= 1'b0;
            cnt  <= '0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy <= 1'b1;
                cnt  <= '0;
            end else if (busy) begin
                cnt <= cnt + 1'b1;
                if (last) begin
                    busy <= 1'b0;
                    done <= 1'b1;   // prod is final from this cycle on
                end
            end
        end
    end

    always_ff @(posedge avm_clk) begin
        if (start) begin
            acc <= a;   // Input assumed below n
        end else if (busy) begin
            acc <= reduced[KEY_W-1:0];
        end
    end

endmodule

//--- logic/rsa_mont_mul.sv
`timescale 1ns/10ps

// Bit-serial Montgomery product a * b * 2^-KEY_W mod n
// b and n must stay stable until done
module rsa_mont_mul #(
    parameter int KEY_W = 256
) (
    input  logic             avm_clk,
    input  logic             avm_rst,
    input  logic             start,
    input  logic [KEY_W-1:0] a,
    input  logic [KEY_W-1:0] b,
    input  logic [KEY_W-1:0] n,
    output logic [KEY_W-1:0] prod,
    output logic             done
);

    localparam int CNT_W = $clog2(KEY_W);

    logic             busy;
    logic [CNT_W-1:0] cnt;
    logic [KEY_W-1:0] a_sh;     // LSB is the multiplier bit of this step
    logic [KEY_W:0]   acc;      // Running sum, stays below 2n
    logic [KEY_W+1:0] sum_b;
    logic [KEY_W+1:0] sum_n;
    logic [KEY_W:0]   half;
    logic [KEY_W:0]   reduced;
    logic             last;

    assign sum_b   = {1'b0, acc} + (a_sh[0] ? {2'b00, b} : '0);
    assign sum_n   = sum_b + (sum_b[0] ? {2'b00, n} : '0);  // Make the sum even
    assign half    = sum_n[KEY_W+1:1];
    // Final correction is folded into the last step
    assign reduced = (half >= {1'b0, n}) ? half - {1'b0, n} : half;
    assign last    = (cnt == CNT_W'(KEY_W - 1));
    assign prod    = acc[KEY_W-1:0];

    always_ff @(posedge avm_clk or negedge avm_rst) begin
        if (!avm_rst) begin
            busy <= 1'b0;
            cnt  <= '0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy <= 1'b1;
                cnt  <= '0;
            end else if (busy) begin
                cnt <= cnt + 1'b1;
                if (last) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge avm_clk) begin
        if (start) begin
            a_sh <= a;
            acc  <= '0;
        end else if (busy) begin
            a_sh <= a_sh >> 1;
            acc  <= last ? reduced : half;
        end
    end

endmodule

//--- logic/rsa_core.sv
`timescale 1ns/10ps

// Right-to-left Montgomery exponentiation, result = a^d mod n
module rsa_core #(
    parameter int KEY_W = 256
) (
    input  logic             avm_clk,
    input  logic             avm_rst,
    input  logic             start,
    input  logic [KEY_W-1:0] a,
    input  logic [KEY_W-1:0] d,
    input  logic [KEY_W-1:0] n,
    output logic [KEY_W-1:0] result,
    output logic             finished
);

    localparam int RND_W = $clog2(KEY_W);

    rsa256_pkg::core_state_t state;

    logic [RND_W-1:0] rnd;
    logic [KEY_W-1:0] d_sh;     // Exponent, LSB is the current bit
    logic [KEY_W-1:0] m;        // Plain-domain product
    logic [KEY_W-1:0] t;        // a^(2^i) in Montgomery form
    logic             issue;
    logic             mul_wait;
    logic             sqr_wait;
    logic             step_done;
    logic             prep_start;
    logic             prep_done;
    logic             mul_start;
    logic             mul_done;
    logic             sqr_start;
    logic             sqr_done;
    logic [KEY_W-1:0] prep_prod;
    logic [KEY_W-1:0] mul_prod;
    logic [KEY_W-1:0] sqr_prod;

    assign prep_start = start && (state == rsa256_pkg::idle);
    assign sqr_start  = issue;
    assign mul_start  = issue && d_sh[0];   // Multiply only on a set bit
    assign step_done  = (state == rsa256_pkg::loop) && !issue &&
                        (!mul_wait || mul_done) && (!sqr_wait || sqr_done);
    assign finished   = (state == rsa256_pkg::done);
    assign result     = m;

    rsa_mod_prod #(.KEY_W(KEY_W)) u_prep (
        .avm_clk (avm_clk),
        .avm_rst (avm_rst),
        .start   (prep_start),
        .a       (a),
        .n       (n),
        .prod    (prep_prod),
        .done    (prep_done)
    );

    rsa_mont_mul #(.KEY_W(KEY_W)) u_mul (
        .avm_clk (avm_clk),
        .avm_rst (avm_rst),
        .start   (mul_start),
        .a       (m),
        .b       (t),
        .n       (n),
        .prod    (mul_prod),
        .done    (mul_done)
    );

    rsa_mont_mul #(.KEY_W(KEY_W)) u_sqr (
        .avm_clk (avm_clk),
        .avm_rst (avm_rst),
        .start   (sqr_start),
        .a       (t),
        .b       (t),
        .n       (n),
        .prod    (sqr_prod),
        .done    (sqr_done)
    );

    always_ff @(posedge avm_clk or negedge avm_rst) begin
        if (!avm_rst) begin
            state    <= rsa256_pkg::idle;
            rnd      <= '0;
            issue    <= 1'b0;
            mul_wait <= 1'b0;
            sqr_wait <= 1'b0;
        end else begin
            issue <= 1'b0;
            if (issue) begin
                mul_wait <= d_sh[0];
                sqr_wait <= 1'b1;
            end
            if (mul_done) mul_wait <= 1'b0;
            if (sqr_done) sqr_wait <= 1'b0;
            case (state)
                rsa256_pkg::idle: if (start) state <= rsa256_pkg::prep;
                rsa256_pkg::prep: begin
                    if (prep_done) begin
                        state <= rsa256_pkg::loop;
                        rnd   <= '0;
                        issue <= 1'b1;
                    end
                end
                rsa256_pkg::loop: begin
                    if (step_done) begin
                        if (rnd == RND_W'(KEY_W - 1)) begin
                            state <= rsa256_pkg::done;
                        end else begin
                            rnd   <= rnd + 1'b1;
                            issue <= 1'b1;
                        end
                    end
                end
                default: state <= rsa256_pkg::idle;     // done lasts one cycle
            endcase
        end
    end

    always_ff @(posedge avm_clk) begin
        if (prep_start) d_sh <= d;
        if (prep_done) begin
            t <= prep_prod;
            m <= KEY_W'(1);
        end
        if (mul_done) m <= mul_prod;
        if (sqr_done) t <= sqr_prod;
        if (step_done) d_sh <= d_sh >> 1;
    end

endmodule

//--- logic/rsa_host_ctrl.sv
`timescale 1ns/10ps

// Avalon-MM master that feeds the core from the serial peripheral
module rsa_host_ctrl #(
    parameter int KEY_W = 256
) (
    input  logic                  avm_clk,
    input  logic                  avm_rst,
    output rsa256_pkg::avm_addr_t avm_address,
    output logic                  avm_read,
    output logic                  avm_write,
    output rsa256_pkg::avm_word_t avm_writedata,
    input  rsa256_pkg::avm_word_t avm_readdata,
    input  logic                  avm_waitrequest,
    output logic                  start,
    output logic [KEY_W-1:0]      a,
    output logic [KEY_W-1:0]      d,
    output logic [KEY_W-1:0]      n,
    input  logic [KEY_W-1:0]      result,
    input  logic                  finished
);

    localparam int KEY_B = KEY_W / 8;
    localparam int CNT_W = $clog2(3 * KEY_B + 1);

    // Byte counter reload values, counting down to 1
    localparam logic [CNT_W-1:0] CNT_KEY = CNT_W'(3 * KEY_B);   // n, d and ciphertext
    localparam logic [CNT_W-1:0] CNT_D   = CNT_W'(2 * KEY_B);
    localparam logic [CNT_W-1:0] CNT_BLK = CNT_W'(KEY_B);       // Ciphertext only
    localparam logic [CNT_W-1:0] CNT_TX  = CNT_W'(KEY_B - 1);   // Top byte is not sent

    rsa256_pkg::ctrl_state_t state;

    logic [CNT_W-1:0] cnt;
    logic [KEY_W-1:0] out_r;
    logic [7:0]       rx_byte;
    logic             rd_done;
    logic             wr_done;

    assign rd_done       = avm_read && !avm_waitrequest;
    assign wr_done       = avm_write && !avm_waitrequest;
    assign rx_byte       = avm_readdata[7:0];
    assign avm_writedata = {24'd0, out_r[KEY_W-9 -: 8]};

    always_ff @(posedge avm_clk or negedge avm_rst) begin
        if (!avm_rst) begin
            state       <= rsa256_pkg::get_key;
            cnt         <= CNT_KEY;
            avm_address <= rsa256_pkg::status_base;
            avm_read    <= 1'b1;
            avm_write   <= 1'b0;
            start       <= 1'b0;
        end else begin
            start <= 1'b0;
            case (state)
                rsa256_pkg::get_key: begin
                    if (rd_done && avm_readdata[rsa256_pkg::rx_ok_bit]) begin
                        avm_address <= rsa256_pkg::rx_base;
                        state       <= rsa256_pkg::get_data;
                    end
                end
                rsa256_pkg::get_data: begin
                    if (rd_done) begin
                        cnt <= cnt - 1'b1;
                        if (cnt == CNT_W'(1)) begin
                            avm_read <= 1'b0;   // Bus idle while the core runs
                            start    <= 1'b1;
                            state    <= rsa256_pkg::wait_calc;
                        end else begin
                            avm_address <= rsa256_pkg::status_base;
                            state       <= rsa256_pkg::get_key;
                        end
                    end
                end
                rsa256_pkg::wait_calc: begin
                    if (finished) begin
                        cnt         <= CNT_TX;
                        avm_read    <= 1'b1;
                        avm_address <= rsa256_pkg::status_base;
                        state       <= rsa256_pkg::get_tx;
                    end
                end
                rsa256_pkg::get_tx: begin
                    if (rd_done && avm_readdata[rsa256_pkg::tx_ok_bit]) begin
                        avm_read    <= 1'b0;
                        avm_write   <= 1'b1;
                        avm_address <= rsa256_pkg::tx_base;
                        state       <= rsa256_pkg::send_data;
                    end
                end
                rsa256_pkg::send_data: begin
                    if (wr_done) begin
                        avm_write   <= 1'b0;
                        avm_read    <= 1'b1;
                        avm_address <= rsa256_pkg::status_base;
                        if (cnt == CNT_W'(1)) begin
                            cnt   <= CNT_BLK;   // Keep the key for the next block
                            state <= rsa256_pkg::get_key;
                        end else begin
                            cnt   <= cnt - 1'b1;
                            state <= rsa256_pkg::get_tx;
                        end
                    end
                end
                default: state <= rsa256_pkg::get_key;
            endcase
        end
    end

    // Key, ciphertext and result shift registers, MSB first
    always_ff @(posedge avm_clk) begin
        if (rd_done && state == rsa256_pkg::get_data) begin
            if (cnt > CNT_D) begin
                n <= {n[KEY_W-9:0], rx_byte};
            end else if (cnt > CNT_BLK) begin
                d <= {d[KEY_W-9:0], rx_byte};
            end else begin
                a <= {a[KEY_W-9:0], rx_byte};
            end
        end
        if (finished && state == rsa256_pkg::wait_calc) begin
            out_r <= result;
        end else if (wr_done) begin
            out_r <= out_r << 8;
        end
    end

endmodule

//--- logic/rsa256_top.sv
`timescale 1ns/10ps

module rsa256_top #(
    parameter int KEY_W = 256   // Multiple of 8
) (
    input  logic                  avm_clk,
    input  logic                  avm_rst,
    output rsa256_pkg::avm_addr_t avm_address,
    output logic                  avm_read,
    output logic                  avm_write,
    output rsa256_pkg::avm_word_t avm_writedata,
    input  rsa256_pkg::avm_word_t avm_readdata,
    input  logic                  avm_waitrequest
);

    logic             start;
    logic             finished;
    logic [KEY_W-1:0] a;
    logic [KEY_W-1:0] d;
    logic [KEY_W-1:0] n;
    logic [KEY_W-1:0] result;

    rsa_host_ctrl #(.KEY_W(KEY_W)) u_ctrl (
        .avm_clk         (avm_clk),
        .avm_rst         (avm_rst),
        .avm_address     (avm_address),
        .avm_read        (avm_read),
        .avm_write       (avm_write),
        .avm_writedata   (avm_writedata),
        .avm_readdata    (avm_readdata),
        .avm_waitrequest (avm_waitrequest),
        .start           (start),
        .a               (a),
        .d               (d),
        .n               (n),
        .result          (result),
        .finished        (finished)
    );

    rsa_core #(.KEY_W(KEY_W)) u_core (
        .avm_clk  (avm_clk),
        .avm_rst  (avm_rst),
        .start    (start),
        .a        (a),
        .d        (d),
        .n        (n),
        .result   (result),
        .finished (finished)
    );

endmodule

//--- verification/rsa256_monitor.sv
`timescale 1ns/10ps

// Collects TX bytes per block and compares them with a modexp model
module rsa256_monitor #(
    parameter int KEY_W = 256
) (
    input logic                  avm_clk,
    input logic                  avm_rst,
    input rsa256_pkg::avm_addr_t avm_address,
    input logic                  avm_write,
    input rsa256_pkg::avm_word_t avm_writedata,
    input logic                  avm_waitrequest
);

    localparam int OUT_B = KEY_W / 8 - 1;  // Top byte is never sent
    localparam logic [KEY_W-1:0] LOW_MASK = {8'd0, {(KEY_W - 8){1'b1}}};

    string            name_q[$];
    logic [KEY_W-1:0] exp_q[$];
    logic [KEY_W-1:0] got;
    int               nbytes = 0;
    int               blocks_done = 0;
    int               pass_cnt = 0;
    int               fail_cnt = 0;

    // Square-and-multiply on double-width products
    function automatic logic [KEY_W-1:0] mod_exp(input logic [KEY_W-1:0] b,
                                                 input logic [KEY_W-1:0] e,
                                                 input logic [KEY_W-1:0] m);
        logic [2*KEY_W-1:0] r;
        logic [2*KEY_W-1:0] x;
        logic [2*KEY_W-1:0] mm;
        mm = {{KEY_W{1'b0}}, m};
        r  = 1;
        x  = {{KEY_W{1'b0}}, b} % mm;
        for (int i = 0; i < KEY_W; i++) begin
            if (e[i]) r = (r * x) % mm;
            x = (x * x) % mm;
        end
        return r[KEY_W-1:0];
    endfunction

    task automatic expect_block(input string name, input logic [KEY_W-1:0] n,
                                input logic [KEY_W-1:0] d, input logic [KEY_W-1:0] c);
        name_q.push_back(name);
        exp_q.push_back(mod_exp(c, d, n));
    endtask

    task automatic check_value(input string name, input logic [KEY_W-1:0] expected,
                               input logic [KEY_W-1:0] actual);
        if (expected === actual) begin
            $display("PASSED %s", name);
            pass_cnt++;
        end else begin
            $display("FAILED %s expected %h actual %h", name, expected, actual);
            fail_cnt++;
        end
    endtask

    task automatic print_counts();
        $display("Tests: %0d passed, %0d failed", pass_cnt, fail_cnt);
    endtask

    always @(posedge avm_clk) begin
        if (!avm_rst) begin
            nbytes = 0;
        end else if (avm_write && !avm_waitrequest && avm_address == rsa256_pkg::tx_base) begin
            if (avm_writedata[31:8] !== 24'd0) begin
                $display("DUT wrote a TX word with nonzero upper bits");
                fail_cnt++;
            end
            if (nbytes == 0) got = '0;
            got = {got[KEY_W-9:0], avm_writedata[7:0]};
            nbytes++;
            if (nbytes == OUT_B) begin
                if (exp_q.size() == 0) begin
                    $display("DUT sent a TX block that no test was waiting for");
                    fail_cnt++;
                end else begin
                    check_value(name_q.pop_front(), exp_q.pop_front() & LOW_MASK, got);
                end
                nbytes = 0;
                blocks_done++;
            end
        end
    end

endmodule

//--- verification/rsa256_chk.sv
`timescale 1ns/10ps

// Avalon master rules, bound into rsa_host_ctrl
module rsa256_chk (
    input logic                  avm_clk,
    input logic                  avm_rst,
    input rsa256_pkg::avm_addr_t avm_address,
    input logic                  avm_read,
    input logic                  avm_write,
    input rsa256_pkg::avm_word_t avm_writedata,
    input logic                  avm_waitrequest
);

    // Command held while the slave stalls
    a_hold_cmd: assert property (@(posedge avm_clk) disable iff (!avm_rst)
        (avm_read || avm_write) && avm_waitrequest |=>
            $stable(avm_address) && $stable(avm_read) && $stable(avm_write) &&
            $stable(avm_writedata))
        else $error("Avalon command changed while waitrequest was high");

    a_one_cmd: assert property (@(posedge avm_clk) disable iff (!avm_rst)
        !(avm_read && avm_write))
        else $error("Read and write asserted together");

    a_reset_state: assert property (@(posedge avm_clk)
        !avm_rst || $rose(avm_rst) |->
            avm_read && !avm_write && avm_address == rsa256_pkg::status_base)
        else $error("Master not polling STATUS after reset");

endmodule

//--- verification/rsa256_tb.sv
`timescale 1ns/10ps

module rsa256_tb;

    localparam int KEY_W   = 256;   // Same as the rsa256_top default
    localparam int KEY_B   = KEY_W / 8;
    localparam int TIMEOUT = 400000;    // Cycles allowed per block

    logic                  avm_clk;
    logic                  avm_rst;
    rsa256_pkg::avm_addr_t avm_address;
    logic                  avm_read;
    logic                  avm_write;
    rsa256_pkg::avm_word_t avm_writedata;
    rsa256_pkg::avm_word_t avm_readdata;
    logic                  avm_waitrequest;

    integer                seed = 95606;
    int                    stall_pct;
    int                    not_ready_pct;
    int                    tx_violations;
    int                    rx_reads;
    int                    rx_underflow;
    int                    blocks_sent;
    logic                  timed_out;
    logic                  last_tx_ok;
    logic [7:0]            rx_q[$];
    rsa256_pkg::avm_word_t stat_word;
    logic [KEY_W-1:0]      key_n;
    logic [KEY_W-1:0]      key_d;

    rsa256_top dut (
        .avm_clk         (avm_clk),
        .avm_rst         (avm_rst),
        .avm_address     (avm_address),
        .avm_read        (avm_read),
        .avm_write       (avm_write),
        .avm_writedata   (avm_writedata),
        .avm_readdata    (avm_readdata),
        .avm_waitrequest (avm_waitrequest)
    );

    rsa256_monitor #(.KEY_W(KEY_W)) mon (
        .avm_clk         (avm_clk),
        .avm_rst         (avm_rst),
        .avm_address     (avm_address),
        .avm_write       (avm_write),
        .avm_writedata   (avm_writedata),
        .avm_waitrequest (avm_waitrequest)
    );

    bind rsa_host_ctrl rsa256_chk u_chk (
        .avm_clk         (avm_clk),
        .avm_rst         (avm_rst),
        .avm_address     (avm_address),
        .avm_read        (avm_read),
        .avm_write       (avm_write),
        .avm_writedata   (avm_writedata),
        .avm_waitrequest (avm_waitrequest)
    );

    always #4 avm_clk = ~avm_clk;

    function automatic logic roll_below(input int pct);
        int r;
        r = $unsigned($random(seed)) % 100;
        return r < pct;
    endfunction

    // Serial peripheral model, one wait state at least per transfer
    always @(posedge avm_clk) begin
        if (!avm_rst) begin
            avm_waitrequest <= 1'b1;
            last_tx_ok = 1'b0;
        end else if (!(avm_read || avm_write)) begin
            avm_waitrequest <= 1'b1;
        end else if (avm_waitrequest) begin
            if (!roll_below(stall_pct)) begin
                avm_waitrequest <= 1'b0;
                if (avm_address == rsa256_pkg::rx_base) begin
                    avm_readdata <= {24'd0, (rx_q.size() > 0) ? rx_q[0] : 8'hee};
                end else if (avm_address == rsa256_pkg::status_base) begin
                    stat_word = '0;
                    stat_word[rsa256_pkg::rx_ok_bit] = (rx_q.size() > 0) &&
                                                       !roll_below(not_ready_pct);
                    stat_word[rsa256_pkg::tx_ok_bit] = !roll_below(not_ready_pct);
                    avm_readdata <= stat_word;
                end else begin
                    avm_readdata <= 32'hdead_beef;
                end
            end
        end else begin
            avm_waitrequest <= 1'b1;    // Transfer completes in this cycle
            if (avm_read && avm_address == rsa256_pkg::status_base) begin
                last_tx_ok = avm_readdata[rsa256_pkg::tx_ok_bit];
            end
            if (avm_read && avm_address == rsa256_pkg::rx_base) begin
                rx_reads++;
                if (rx_q.size() > 0) begin
                    rx_q.delete(0);
                end else begin
                    rx_underflow++;
                end
            end
            if (avm_write && avm_address == rsa256_pkg::tx_base) begin
                if (!last_tx_ok) tx_violations++;
                last_tx_ok = 1'b0;
            end
        end
    end

    function automatic logic [KEY_W-1:0] rand_word();
        logic [KEY_W-1:0] w;
        w = '0;
        for (int i = 0; i < KEY_W / 32; i++) begin
            w = {w[KEY_W-33:0], $random(seed)};
        end
        return w;
    endfunction

    task automatic push_bytes(input logic [KEY_W-1:0] value);
        for (int i = KEY_B - 1; i >= 0; i--) begin
            rx_q.push_back(value[i*8 +: 8]);
        end
    endtask

    task automatic finish_run();
        mon.print_counts();
        if (timed_out || mon.fail_cnt > 0) begin
            $display("SIMULATION FAILED");
        end else begin
            $display("SIMULATION PASSED");
        end
        $finish;
    endtask

    task automatic wait_blocks(input int target);
        int cycles;
        cycles = 0;
        while (mon.blocks_done < target && cycles < TIMEOUT) begin
            @(posedge avm_clk);
            cycles++;
        end
        if (mon.blocks_done < target) begin
            $display("Timeout while waiting for TX block %0d from the DUT", target);
            timed_out = 1'b1;
        end
    endtask

    task automatic run_block(input string name, input logic [KEY_W-1:0] c);
        if (!timed_out) begin
            push_bytes(c);
            mon.expect_block(name, key_n, key_d, c);
            blocks_sent++;
            wait_blocks(blocks_sent);
        end
    endtask

    task automatic apply_reset();
        avm_rst <= 1'b0;
        repeat (3) @(posedge avm_clk);
        avm_rst <= 1'b1;
    endtask

    initial begin
        avm_clk         = 1'b0;
        avm_rst         = 1'b1;     // Falls at time zero in apply_reset
        avm_readdata    = '0;
        avm_waitrequest = 1'b1;
        stall_pct       = 30;
        not_ready_pct   = 20;
        tx_violations   = 0;
        rx_reads        = 0;
        rx_underflow    = 0;
        blocks_sent     = 0;
        timed_out       = 1'b0;
        apply_reset();

        key_n = rand_word();
        key_n[KEY_W-1] = 1'b1;
        key_n[0] = 1'b1;
        key_d = rand_word();
        key_d[KEY_W-1] = 1'b0;  // Keeps d below n
        push_bytes(key_n);
        push_bytes(key_d);
        run_block("first_block", rand_word() >> 1);
        run_block("key_reuse", rand_word() >> 1);
        run_block("key_reuse", rand_word() >> 1);
        run_block("key_reuse", rand_word() >> 1);
        stall_pct     = 70;
        not_ready_pct = 50;
        run_block("backpressure", rand_word() >> 1);
        stall_pct     = 30;
        not_ready_pct = 20;
        mon.check_value("key_reuse", KEY_W'(7 * KEY_B), KEY_W'(rx_reads + rx_underflow));
        run_block("edge_values", '0);
        run_block("edge_values", KEY_W'(1));
        mon.check_value("tx_gating", '0, KEY_W'(tx_violations));

        // New key with exponent 1 needs a fresh reset
        apply_reset();
        key_d = KEY_W'(1);
        push_bytes(key_n);
        push_bytes(key_d);
        run_block("edge_values", rand_word() >> 1);
        mon.check_value("tx_gating", '0, KEY_W'(tx_violations));
        finish_run();
    end

endmodule

//--- rsa256.f
logic/rsa256_pkg.sv
logic/rsa_mod_prod.sv
logic/rsa_mont_mul.sv
logic/rsa_core.sv
logic/rsa_host_ctrl.sv
logic/rsa256_top.sv
verification/rsa256_monitor.sv
verification/rsa256_chk.sv
verification/rsa256_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator; result is read from sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -f rsa256.f --top-module rsa256_tb \
    -o rsa256_sim > sim.log 2>&1 &&
    ./obj_dir/rsa256_sim >> sim.log 2>&1 ||
    echo "SIMULATION FAILED" >> sim.log

cat sim.log
grep -q "SIMULATION FAILED" sim.log && exit 1
grep -q "SIMULATION PASSED" sim.log || exit 1
exit 0
